// File: src/chessPkg.sv
package chessPkg;

    localparam int boardDim = 8;   // rows and columns

    typedef enum logic [2:0] {
        empty  = 3'd0,
        pawn   = 3'd1,
        bishop = 3'd2,
        knight = 3'd3,
        rook   = 3'd4,
        queen  = 3'd5,
        king   = 3'd6
    } pieceKind;

    typedef enum logic {
        white = 1'b0,
        black = 1'b1
    } side;

    // owner sits in bit 3, kind in bits 2:0
    typedef struct packed {
        side      owner;
        pieceKind kind;
    } square;

    typedef struct packed {
        logic [2:0] row;   // 0 is black's back rank
        logic [2:0] col;
    } coord;

    typedef logic [boardDim*boardDim-1:0] moveMask;   // bit row*8 + col

    typedef struct packed {
        coord  from;
        coord  to;
        square piece;
    } moveRecord;

    localparam square emptySquare = '{owner: white, kind: empty};
    localparam logic [2:0] blackStartRow = 3'd1;   // black pawns
    localparam logic [2:0] whiteStartRow = 3'd6;   // white pawns

    // starting layout, one square at a time
    function automatic square openingRow(input logic [2:0] row, input logic [2:0] col);
        square    sq;
        pieceKind backRank;
        case (col)
            3'd0, 3'd7: backRank = rook;
            3'd1, 3'd6: backRank = knight;
            3'd2, 3'd5: backRank = bishop;
            3'd3:       backRank = queen;
            default:    backRank = king;
        endcase
        sq.owner = (row <= blackStartRow) ? black : white;
        if (row == 3'd0 || row == 3'd7) begin
            sq.kind = backRank;
        end else if (row == blackStartRow || row == whiteStartRow) begin
            sq.kind = pawn;
        end else begin
            sq = emptySquare;
        end
        return sq;
    endfunction

endpackage

// File: src/boardStore.sv
`timescale 1ns/1ps

module boardStore import chessPkg::*; (
    input  logic      CLOCK,
    input  logic      reset,
    input  coord      readA,         // turn control side
    input  coord      readB,         // move generator probe
    input  logic      writeEnable,
    input  moveRecord writeMove,
    output square     squareA,
    output square     squareB
);

    square board [boardDim*boardDim];

    logic [5:0] addrA;
    logic [5:0] addrB;
    logic [5:0] addrFrom;
    logic [5:0] addrTo;

    ////////////////////////////////////////////////////////////////////////////
    // address flattening, row*8 + col
    ////////////////////////////////////////////////////////////////////////////

    assign addrA    = {readA.row, readA.col};
    assign addrB    = {readB.row, readB.col};
    assign addrFrom = {writeMove.from.row, writeMove.from.col};
    assign addrTo   = {writeMove.to.row, writeMove.to.col};

    // both read ports are purely combinational
    assign squareA = board[addrA];
    assign squareB = board[addrB];

    ////////////////////////////////////////////////////////////////////////////
    // opening layout on reset, one move per write strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLOCK) begin
        if (reset) begin
            for (int r = 0; r < boardDim; r++) begin
                for (int c = 0; c < boardDim; c++) begin
                    board[r*boardDim + c] <= openingRow(3'(r), 3'(c));
                end
            end
        end else if (writeEnable) begin
            board[addrFrom] <= emptySquare;      // vacate origin
            board[addrTo]   <= writeMove.piece;  // captured piece simply overwritten
        end
    end

endmodule

// File: src/moveGenerator.sv
`timescale 1ns/1ps

module moveGenerator import chessPkg::*; (
    input  logic    CLOCK,
    input  logic    reset,
    input  logic    startScan,
    input  coord    origin,
    input  square   mover,
    input  square   probeSquare,
    input  logic    clearMask,      // a move was just written
    output coord    probeAt,
    output logic    busy,
    output moveMask availMoves
);

    typedef struct packed {
        logic signed [4:0] dRow;
        logic signed [4:0] dCol;
    } offset;

    logic [2:0]        dirIdx;
    logic              extended;    // pawn already took its first step
    logic signed [4:0] curRow;      // wide enough for off-board knights
    logic signed [4:0] curCol;
    logic signed [4:0] originRow;
    logic signed [4:0] originCol;
    logic [2:0]        homeRow;
    logic              onBoard;
    logic              targetEmpty;
    logic              targetEnemy;
    logic              markIt;
    logic              keepGoing;
    offset             curStep;
    offset             nextStep;
    offset             firstStep;

    ////////////////////////////////////////////////////////////////////////////
    // direction tables
    ////////////////////////////////////////////////////////////////////////////

    function automatic offset stepFor(input square piece, input logic [2:0] idx);
        offset step;
        step = '{dRow: 5'sd0, dCol: 5'sd0};
        case (piece.kind)
            knight: begin
                case (idx)
                    3'd0:    step = '{-5'sd2, -5'sd1};
                    3'd1:    step = '{-5'sd2,  5'sd1};
                    3'd2:    step = '{-5'sd1, -5'sd2};
                    3'd3:    step = '{-5'sd1,  5'sd2};
                    3'd4:    step = '{ 5'sd1, -5'sd2};
                    3'd5:    step = '{ 5'sd1,  5'sd2};
                    3'd6:    step = '{ 5'sd2, -5'sd1};
                    default: step = '{ 5'sd2,  5'sd1};
                endcase
            end
            pawn: begin
                step.dRow = (piece.owner == white) ? -5'sd1 : 5'sd1;  // white heads to row 0
                step.dCol = (idx == 3'd1) ? -5'sd1 : ((idx == 3'd2) ? 5'sd1 : 5'sd0);
            end
            default: begin
                case (idx)
                    3'd0:    step = '{-5'sd1,  5'sd0};  // orthogonals first
                    3'd1:    step = '{ 5'sd1,  5'sd0};
                    3'd2:    step = '{ 5'sd0, -5'sd1};
                    3'd3:    step = '{ 5'sd0,  5'sd1};
                    3'd4:    step = '{-5'sd1, -5'sd1};  // then diagonals
                    3'd5:    step = '{-5'sd1,  5'sd1};
                    3'd6:    step = '{ 5'sd1, -5'sd1};
                    default: step = '{ 5'sd1,  5'sd1};
                endcase
            end
        endcase
        return step;
    endfunction

    function automatic logic [2:0] firstDir(input pieceKind kind);
        return (kind == bishop) ? 3'd4 : 3'd0;
    endfunction

    function automatic logic [2:0] lastDir(input pieceKind kind);
        case (kind)
            pawn:                   return 3'd2;  // push, two captures
            rook:                   return 3'd3;
            bishop, knight, queen:  return 3'd7;
            default:                return 3'd0;  // king and empty end at once
        endcase
    endfunction

    assign curStep   = stepFor(mover, dirIdx);
    assign nextStep  = stepFor(mover, dirIdx + 3'd1);
    assign firstStep = stepFor(mover, firstDir(mover.kind));
    assign originRow = {2'b00, origin.row};
    assign originCol = {2'b00, origin.col};
    assign homeRow   = (mover.owner == white) ? whiteStartRow : blackStartRow;

    assign probeAt = '{row: curRow[2:0], col: curCol[2:0]};
    assign onBoard = (curRow >= 0) && (curRow < boardDim) && (curCol >= 0) && (curCol < boardDim);

    assign targetEmpty = (probeSquare.kind == empty);
    assign targetEnemy = !targetEmpty && (probeSquare.owner != mover.owner);

    // target rule for the square under the cursor
    always_comb begin
        markIt    = 1'b0;
        keepGoing = 1'b0;
        if (onBoard) begin
            case (mover.kind)
                rook, bishop, queen: begin
                    markIt    = targetEmpty || targetEnemy;
                    keepGoing = targetEmpty;              // stop at first occupied square
                end
                knight: begin
                    markIt = targetEmpty || targetEnemy;
                end
                pawn: begin
                    if (dirIdx == 3'd0) begin
                        markIt    = targetEmpty;
                        keepGoing = targetEmpty && !extended && (origin.row == homeRow);
                    end else begin
                        markIt = targetEnemy;             // diagonal only onto a capture
                    end
                end
                default: begin
                    markIt = 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ray walker
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLOCK) begin
        if (reset) begin
            busy       <= 1'b0;
            availMoves <= '0;
            dirIdx     <= '0;
            extended   <= 1'b0;
            curRow     <= '0;
            curCol     <= '0;
        end else if (startScan) begin
            busy       <= 1'b1;
            availMoves <= '0;
            dirIdx     <= firstDir(mover.kind);
            extended   <= 1'b0;
            curRow     <= originRow + firstStep.dRow;
            curCol     <= originCol + firstStep.dCol;
        end else if (busy) begin
            if (markIt) begin
                availMoves[{probeAt.row, probeAt.col}] <= 1'b1;
            end
            if (keepGoing) begin
                curRow   <= curRow + curStep.dRow;   // further along the same ray
                curCol   <= curCol + curStep.dCol;
                extended <= 1'b1;
            end else if (dirIdx == lastDir(mover.kind)) begin
                busy <= 1'b0;
            end else begin
                dirIdx   <= dirIdx + 3'd1;
                extended <= 1'b0;
                curRow   <= originRow + nextStep.dRow;
                curCol   <= originCol + nextStep.dCol;
            end
        end else if (clearMask) begin
            availMoves <= '0;
        end
    end

endmodule

// File: src/turnControl.sv
`timescale 1ns/1ps

module turnControl import chessPkg::*; (
    input  logic       CLOCK,
    input  logic       reset,
    input  logic       pick,
    input  side        player,
    input  logic [2:0] coordX,
    input  logic [2:0] coordY,
    input  square      pickedSquare,   // board at the picked coordinate
    input  logic       busy,
    input  moveMask    availMoves,
    output coord       pickAt,
    output logic       startScan,
    output coord       selOrigin,
    output square      selPiece,
    output logic       writeEnable,
    output moveRecord  writeMove,
    output logic [2:0] oldPosX,
    output logic [2:0] oldPosY,
    output logic [2:0] newPosX,
    output logic [2:0] newPosY,
    output logic       moved
);

    logic haveSel;      // a piece is selected
    logic accept;
    logic ownPiece;
    logic maskHit;
    logic selectNow;

    assign pickAt = '{row: coordX, col: coordY};

    // no picks during a scan, including its launch cycle
    assign accept    = pick && !busy && !startScan;
    assign ownPiece  = (pickedSquare.kind != empty) && (pickedSquare.owner == player);
    assign maskHit   = haveSel && availMoves[{coordX, coordY}];
    assign selectNow = accept && ownPiece;

    // write lands on the edge after the pick
    assign writeEnable = accept && !ownPiece && maskHit;
    assign writeMove   = '{from: selOrigin, to: pickAt, piece: selPiece};

    ////////////////////////////////////////////////////////////////////////////
    // selection and move bookkeeping
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLOCK) begin
        if (reset) begin
            haveSel   <= 1'b0;
            startScan <= 1'b0;
            moved     <= 1'b0;
            oldPosX   <= '0;
            oldPosY   <= '0;
            newPosX   <= '0;
            newPosY   <= '0;
        end else begin
            startScan <= selectNow;     // one-cycle launch
            moved     <= writeEnable;   // one-cycle pulse
            if (selectNow) begin
                haveSel <= 1'b1;
                oldPosX <= coordX;
                oldPosY <= coordY;
            end else if (writeEnable) begin
                haveSel <= 1'b0;        // selection dropped after the move
                newPosX <= coordX;
                newPosY <= coordY;
            end
        end
    end

    always_ff @(posedge CLOCK) begin
        if (selectNow) begin
            selOrigin <= pickAt;
            selPiece  <= pickedSquare;
        end
    end

endmodule

// File: src/chessEngine.sv
`timescale 1ns/1ps

module chessEngine import chessPkg::*; (
    input  logic       CLOCK,
    input  logic       reset,
    input  logic       pick,
    input  side        player,
    input  logic [2:0] coordX,     // row
    input  logic [2:0] coordY,     // column
    output logic [2:0] oldPosX,
    output logic [2:0] oldPosY,
    output logic [2:0] newPosX,
    output logic [2:0] newPosY,
    output logic       moved,
    output logic       busy,
    output moveMask    availMoves
);

    coord      pickAt;
    coord      probeAt;
    coord      selOrigin;
    square     squareA;
    square     squareB;
    square     selPiece;
    logic      startScan;
    logic      writeEnable;
    moveRecord writeMove;

    ////////////////////////////////////////////////////////////////////////////
    // board, generator, turn control
    ////////////////////////////////////////////////////////////////////////////

    boardStore store (
        .CLOCK       (CLOCK),
        .reset       (reset),
        .readA       (pickAt),
        .readB       (probeAt),
        .writeEnable (writeEnable),
        .writeMove   (writeMove),
        .squareA     (squareA),
        .squareB     (squareB)
    );

    moveGenerator generator (
        .CLOCK       (CLOCK),
        .reset       (reset),
        .startScan   (startScan),
        .origin      (selOrigin),
        .mover       (selPiece),
        .probeSquare (squareB),
        .clearMask   (writeEnable),   // mask drops with the board write
        .probeAt     (probeAt),
        .busy        (busy),
        .availMoves  (availMoves)
    );

    turnControl control (
        .CLOCK        (CLOCK),
        .reset        (reset),
        .pick         (pick),
        .player       (player),
        .coordX       (coordX),
        .coordY       (coordY),
        .pickedSquare (squareA),
        .busy         (busy),
        .availMoves   (availMoves),
        .pickAt       (pickAt),
        .startScan    (startScan),
        .selOrigin    (selOrigin),
        .selPiece     (selPiece),
        .writeEnable  (writeEnable),
        .writeMove    (writeMove),
        .oldPosX      (oldPosX),
        .oldPosY      (oldPosY),
        .newPosX      (newPosX),
        .newPosY      (newPosY),
        .moved        (moved)
    );

endmodule

// File: testbench/chessEngine_assertions.sv
`timescale 1ns/1ps

module chessEngineAssertions import chessPkg::*; (
    input logic    CLOCK,
    input logic    reset,
    input logic    pick,
    input logic    startScan,
    input logic    moved,
    input logic    busy,
    input moveMask availMoves
);

    int failures = 0;   // tally of failed checks

    ////////////////////////////////////////////////////////////////////////////
    // top-level timing rules
    ////////////////////////////////////////////////////////////////////////////

    movedSingle: assert property (@(posedge CLOCK) disable iff (reset) moved |=> !moved)
        else begin
            $error("moved stayed high for two cycles");
            failures++;
        end

    quietAfterReset: assert property (@(posedge CLOCK) $fell(reset) |-> (!moved && !busy))
        else begin
            $error("moved or busy set in the cycle after reset");
            failures++;
        end

    // mask already cleared by the board write
    clearAfterMove: assert property (@(posedge CLOCK) disable iff (reset)
        moved |=> (availMoves == '0))
        else begin
            $error("availMoves not cleared after a move");
            failures++;
        end

    maskHolds: assert property (@(posedge CLOCK) disable iff (reset)
        (!busy && !pick && !startScan) |=> $stable(availMoves))
        else begin
            $error("availMoves changed while idle");
            failures++;
        end

endmodule

// File: testbench/chessEngineTb.sv
`timescale 1ns/1ps

module chessEngineTb import chessPkg::*; ();

    logic       CLOCK;
    logic       reset;
    logic       pick;
    side        player;
    logic [2:0] coordX;
    logic [2:0] coordY;
    logic [2:0] oldPosX;
    logic [2:0] oldPosY;
    logic [2:0] newPosX;
    logic [2:0] newPosY;
    logic       moved;
    logic       busy;
    moveMask    availMoves;

    integer     seed;
    logic [2:0] pickRow;
    logic [2:0] pickCol;
    int         errors;
    int         errorsAtStart;
    int         testCount;
    int         failedTests;

    chessEngine uut (
        .CLOCK(CLOCK), .reset(reset), .pick(pick), .player(player),
        .coordX(coordX), .coordY(coordY),
        .oldPosX(oldPosX), .oldPosY(oldPosY), .newPosX(newPosX), .newPosY(newPosY),
        .moved(moved), .busy(busy), .availMoves(availMoves)
    );

    bind chessEngine chessEngineAssertions checks (
        .CLOCK(CLOCK), .reset(reset), .pick(pick), .startScan(startScan),
        .moved(moved), .busy(busy), .availMoves(availMoves)
    );

    always #50 CLOCK = ~CLOCK;   // 100 ns period

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic moveMask bitAt(input int row, input int col);
        moveMask m;
        m = '0;
        m[row*boardDim + col] = 1'b1;
        return m;
    endfunction

    task automatic checkMask(input moveMask expected);
        assert (availMoves == expected) else begin
            $display("Error: availMoves expected %h got %h", expected, availMoves);
            errors++;
        end
    endtask

    task automatic checkPos(input string name, input logic [2:0] got, input logic [2:0] expected);
        assert (got == expected) else begin
            $display("Error: %s expected %h got %h", name, expected, got);
            errors++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic expected);
        assert (got == expected) else begin
            $display("Error: %s expected %h got %h", name, expected, got);
            errors++;
        end
    endtask

    task automatic applyReset();
        reset = 1'b1;
        pick  = 1'b0;
        repeat (4) @(posedge CLOCK);
        #1 reset = 1'b0;
    endtask

    // one-cycle strobe, starting 1 ns after an edge
    task automatic pickSquare(input side who, input logic [2:0] row, input logic [2:0] col);
        player = who;
        coordX = row;
        coordY = col;
        pick   = 1'b1;
        @(posedge CLOCK);
        #1 pick = 1'b0;
    endtask

    task automatic waitScan();
        int cycles;
        cycles = 0;
        while (!busy && cycles < 10) begin
            @(posedge CLOCK);
            #1 cycles++;
        end
        if (!busy) begin
            $display("timeout: the scan never started after the pick");
            errors++;
        end
        cycles = 0;
        while (busy && cycles < 100) begin
            @(posedge CLOCK);
            #1 cycles++;
        end
        if (busy) begin
            $display("timeout: busy never fell at the end of the scan");
            errors++;
        end
    endtask

    task automatic selectPiece(input side who, input logic [2:0] row, input logic [2:0] col);
        pickSquare(who, row, col);
        waitScan();
        checkPos("oldPosX", oldPosX, row);
        checkPos("oldPosY", oldPosY, col);
    endtask

    task automatic makeMove(input side who, input logic [2:0] row, input logic [2:0] col);
        int cycles;
        cycles = 0;
        pickSquare(who, row, col);
        while (!moved && cycles < 10) begin
            @(posedge CLOCK);
            #1 cycles++;
        end
        if (!moved) begin
            $display("timeout: the move to a marked square never happened");
            errors++;
        end
        checkPos("newPosX", newPosX, row);
        checkPos("newPosY", newPosY, col);
        checkMask('0);
    endtask

    task automatic confirmIdle();
        repeat (3) begin
            @(posedge CLOCK);
            #1;
            checkBit("busy", busy, 1'b0);
            checkMask('0);
        end
    endtask

    task automatic reportTest(input string name);
        testCount++;
        if (errors == errorsAtStart) begin
            $display("test %0d %s ok", testCount, name);
        end else begin
            $display("test %0d %s failed with %0d errors", testCount, name, errors - errorsAtStart);
            failedTests++;
        end
        errorsAtStart = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        CLOCK = 1'b0;
        reset = 1'b1;
        pick = 1'b0;
        player = white;
        coordX = '0;
        coordY = '0;
        seed = 75167;
        errors = 0;
        errorsAtStart = 0;
        testCount = 0;
        failedTests = 0;

        applyReset();
        checkBit("moved", moved, 1'b0);
        checkBit("busy", busy, 1'b0);
        checkMask('0);
        reportTest("after reset");

        selectPiece(white, 3'd6, 3'd4);
        checkMask(bitAt(5, 4) | bitAt(4, 4));   // double step from start row
        reportTest("pawn from start row");

        applyReset();
        for (int i = 0; i < 4; i++) begin
            pickRow = 3'(2 + ($random(seed) & 3));   // middle rows
            pickCol = 3'($random(seed) & 7);
            pickSquare(white, pickRow, pickCol);
            confirmIdle();
        end
        pickSquare(white, 3'd0, 3'd3);   // black queen
        confirmIdle();
        reportTest("ignored picks");

        selectPiece(white, 3'd7, 3'd1);
        checkMask(bitAt(5, 0) | bitAt(5, 2));
        reportTest("knight with own blocker");

        selectPiece(white, 3'd6, 3'd4);
        makeMove(white, 3'd4, 3'd4);
        selectPiece(white, 3'd7, 3'd5);
        checkMask(bitAt(6, 4) | bitAt(5, 3) | bitAt(4, 2) | bitAt(3, 1) | bitAt(2, 0));
        reportTest("move then slide");

        selectPiece(black, 3'd1, 3'd3);
        checkMask(bitAt(2, 3) | bitAt(3, 3));
        makeMove(black, 3'd3, 3'd3);
        selectPiece(white, 3'd6, 3'd2);   // clears the queen's diagonal
        checkMask(bitAt(5, 2) | bitAt(4, 2));
        makeMove(white, 3'd5, 3'd2);
        selectPiece(white, 3'd7, 3'd3);
        checkMask(bitAt(6, 2) | bitAt(5, 1) | bitAt(4, 0) | bitAt(6, 4) | bitAt(5, 5)
                  | bitAt(4, 6) | bitAt(3, 7));
        makeMove(white, 3'd4, 3'd0);
        selectPiece(white, 3'd4, 3'd0);
        // captures at (1,0) and the black king at (0,4)
        checkMask(bitAt(3, 0) | bitAt(2, 0) | bitAt(1, 0) | bitAt(5, 0)
                  | bitAt(4, 1) | bitAt(4, 2) | bitAt(4, 3)
                  | bitAt(3, 1) | bitAt(2, 2) | bitAt(1, 3) | bitAt(0, 4)
                  | bitAt(5, 1) | bitAt(6, 2) | bitAt(7, 3));
        reportTest("slide onto opponent");

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 testCount, failedTests, errors, uut.checks.failures);
        if (errors == 0 && uut.checks.failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: chessEngine.f
src/chessPkg.sv
src/boardStore.sv
src/moveGenerator.sv
src/turnControl.sv
src/chessEngine.sv
testbench/chessEngine_assertions.sv
testbench/chessEngineTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= chessEngineTb
FILELIST  ?= chessEngine.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the exit status comes from the search for the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
